/* hdl/vcore_pkg.sv */
package vcore_pkg;

  parameter int reg_els_gp = 32;
  parameter int reg_addr_width_gp = $clog2(reg_els_gp);
  parameter int data_width_gp = 32;
  parameter int pc_width_gp = 32;

  typedef logic [reg_addr_width_gp-1:0] reg_addr_t;
  typedef logic [data_width_gp-1:0] data_t;
  typedef logic [pc_width_gp-1:0] pc_t;

  typedef struct packed {
    pc_t       pc;
    reg_addr_t rd;
    logic      writes_rf;
    logic      remote_load;
    data_t     data;
  } instr_s;

  typedef struct packed {
    logic      valid;
    pc_t       pc;
    reg_addr_t rd;
    logic      writes_rf;
    data_t     data;
  } stage_s;

  typedef struct packed {
    reg_addr_t reg_id;
    pc_t       pc;
  } remote_req_s;

  // force_wb asks for the write port even when the wb stage is busy
  typedef struct packed {
    reg_addr_t rd;
    data_t     data;
    logic      force_wb;
  } remote_resp_s;

  typedef struct packed {
    logic      valid;
    reg_addr_t addr;
    data_t     data;
  } rf_write_s;

  typedef struct packed {
    reg_addr_t rd;
    pc_t       aggressor_pc;
    pc_t       victim_pc;
    logic      in_wb;
  } waw_report_s;

  typedef enum logic {
    ARB_IDLE,
    ARB_FORCE
  } arb_state_e;

endpackage

/* hdl/exe_pipe.sv */
`timescale 1ns/1ps

module exe_pipe (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    instr_v_i,
  input  vcore_pkg::instr_s       instr_i,
  input  logic                    stall_i,
  output logic                    remote_req_v_o,
  output vcore_pkg::remote_req_s  remote_req_o,
  output vcore_pkg::stage_s       mem_o,
  output vcore_pkg::stage_s       wb_o
);

  import vcore_pkg::*;

  stage_s exe_r;
  stage_s mem_r;
  stage_s wb_r;
  stage_s exe_n;

  // the stage struct has no room for the remote flag, so exe keeps it beside
  logic exe_remote_r;
  logic exe_remote_n;

  always_comb begin
    exe_n.valid = instr_v_i;
    exe_n.pc = instr_i.pc;
    exe_n.rd = instr_i.rd;
    exe_n.data = instr_i.data;
    // a remote load writes later through the response FIFO, never in its own wb
    exe_n.writes_rf = instr_v_i & instr_i.writes_rf & ~instr_i.remote_load;
    exe_remote_n = instr_v_i & instr_i.remote_load;
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      exe_r <= '0;
      mem_r <= '0;
      wb_r <= '0;
      exe_remote_r <= 1'b0;
    end else if (!stall_i) begin
      exe_r <= exe_n;
      exe_remote_r <= exe_remote_n;
      mem_r <= exe_r;
      wb_r <= mem_r;
    end
  end

  // the request leaves only in the cycle that exe actually advances
  assign remote_req_v_o = exe_r.valid & exe_remote_r & ~stall_i;
  assign remote_req_o.reg_id = exe_r.rd;
  assign remote_req_o.pc = exe_r.pc;

  assign mem_o = mem_r;
  assign wb_o = wb_r;

endmodule

/* hdl/remote_resp_fifo.sv */
`timescale 1ns/1ps

module remote_resp_fifo #(
  parameter int resp_fifo_depth_p = 4
) (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    push_i,
  input  vcore_pkg::remote_resp_s push_data_i,
  input  logic                    pop_i,
  output logic                    head_v_o,
  output vcore_pkg::remote_resp_s head_o,
  output logic                    overflow_o
);

  import vcore_pkg::*;

  localparam int ptr_width_lp = (resp_fifo_depth_p > 1) ? $clog2(resp_fifo_depth_p) : 1;
  localparam int cnt_width_lp = $clog2(resp_fifo_depth_p + 1);

  typedef logic [ptr_width_lp-1:0] ptr_t;
  typedef logic [cnt_width_lp-1:0] cnt_t;

  remote_resp_s mem_r [resp_fifo_depth_p];
  ptr_t rd_ptr_r;
  ptr_t wr_ptr_r;
  cnt_t count_r;
  logic overflow_r;
  logic full;
  logic do_push;
  logic do_pop;

  // pointers wrap explicitly so depths that are not a power of two also work
  function automatic ptr_t ptr_inc(ptr_t ptr);
    return (ptr == ptr_t'(resp_fifo_depth_p - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full = (count_r == cnt_t'(resp_fifo_depth_p));
  assign do_push = push_i & ~full;
  assign do_pop = pop_i & head_v_o;

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_r[wr_ptr_r] <= push_data_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_ptr_r <= '0;
      wr_ptr_r <= '0;
      count_r <= '0;
      overflow_r <= 1'b0;
    end else begin
      if (do_push) begin
        wr_ptr_r <= ptr_inc(wr_ptr_r);
      end
      if (do_pop) begin
        rd_ptr_r <= ptr_inc(rd_ptr_r);
      end
      if (do_push && !do_pop) begin
        count_r <= count_r + 1'b1;
      end else if (do_pop && !do_push) begin
        count_r <= count_r - 1'b1;
      end
      // a response lost to a full FIFO is sticky until reset
      if (push_i && full) begin
        overflow_r <= 1'b1;
      end
    end
  end

  assign head_v_o = (count_r != '0);
  assign head_o = mem_r[rd_ptr_r];
  assign overflow_o = overflow_r;

endmodule

/* hdl/rf_write_arbiter.sv */
`timescale 1ns/1ps

module rf_write_arbiter (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  vcore_pkg::stage_s       wb_i,
  input  logic                    head_v_i,
  input  vcore_pkg::remote_resp_s head_i,
  output logic                    pop_o,
  output logic                    stall_o,
  output logic                    force_grant_o,
  output vcore_pkg::rf_write_s    rf_write_o
);

  import vcore_pkg::*;

  arb_state_e state_r;
  arb_state_e state_n;
  logic wb_writes;
  logic grant_wb;
  logic grant_head;

  assign wb_writes = wb_i.valid & wb_i.writes_rf;

  // ARB_FORCE is the cycle right after a forced write, the held wb stage gets
  // the port first there so a stall never lasts more than one cycle
  always_comb begin
    state_n = state_r;
    grant_wb = 1'b0;
    grant_head = 1'b0;
    stall_o = 1'b0;
    force_grant_o = 1'b0;
    case (state_r)
      ARB_IDLE: begin
        if (head_v_i && head_i.force_wb) begin
          grant_head = 1'b1;
          stall_o = 1'b1;
          force_grant_o = 1'b1;
          state_n = ARB_FORCE;
        end else if (wb_writes) begin
          grant_wb = 1'b1;
        end else if (head_v_i) begin
          grant_head = 1'b1;
        end
      end
      ARB_FORCE: begin
        state_n = ARB_IDLE;
        if (wb_writes) begin
          grant_wb = 1'b1;
        end else if (head_v_i) begin
          grant_head = 1'b1;
        end
      end
      default: begin
        state_n = ARB_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= ARB_IDLE;
    end else begin
      state_r <= state_n;
    end
  end

  assign pop_o = grant_head;
  assign rf_write_o.valid = grant_wb | grant_head;
  assign rf_write_o.addr = grant_head ? head_i.rd : wb_i.rd;
  assign rf_write_o.data = grant_head ? head_i.data : wb_i.data;

endmodule

/* hdl/regfile.sv */
`timescale 1ns/1ps

module regfile (
  input  logic                 clk_i,
  input  logic                 reset_i,
  input  vcore_pkg::rf_write_s write_i,
  input  vcore_pkg::reg_addr_t raddr_i,
  output vcore_pkg::data_t     rdata_o
);

  import vcore_pkg::*;

  data_t rf_r [reg_els_gp];

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < reg_els_gp; i++) begin
        rf_r[i] <= '0;
      end
    end else if (write_i.valid && (write_i.addr != '0)) begin
      // x0 is never written, so it keeps the zero from reset
      rf_r[write_i.addr] <= write_i.data;
    end
  end

  assign rdata_o = rf_r[raddr_i];

endmodule

/* hdl/waw_detector.sv */
`timescale 1ns/1ps

module waw_detector (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   remote_req_v_i,
  input  vcore_pkg::remote_req_s remote_req_i,
  input  logic                   force_grant_i,
  input  vcore_pkg::reg_addr_t   forced_rd_i,
  input  vcore_pkg::stage_s      mem_i,
  input  vcore_pkg::stage_s      wb_i,
  output logic                   waw_v_o,
  output vcore_pkg::waw_report_s waw_o
);

  import vcore_pkg::*;

  // pc of the last remote load issued for each destination register
  pc_t req_pc_r [reg_els_gp];
  logic [reg_els_gp-1:0] req_seen_r;

  logic wb_hit;
  logic mem_hit;
  logic forced_known;

  always_ff @(posedge clk_i) begin
    if (remote_req_v_i) begin
      req_pc_r[remote_req_i.reg_id] <= remote_req_i.pc;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      req_seen_r <= '0;
    end else if (remote_req_v_i) begin
      req_seen_r[remote_req_i.reg_id] <= 1'b1;
    end
  end

  assign wb_hit = wb_i.valid & wb_i.writes_rf & (wb_i.rd == forced_rd_i);
  assign mem_hit = mem_i.valid & mem_i.writes_rf & (mem_i.rd == forced_rd_i);

  // x0 writes are discarded anyway, so they cannot collide
  assign forced_known = req_seen_r[forced_rd_i] & (forced_rd_i != '0);

  assign waw_v_o = force_grant_i & forced_known & (wb_hit | mem_hit);

  // wb is older than mem, so it is the victim named when both match
  assign waw_o.rd = forced_rd_i;
  assign waw_o.aggressor_pc = req_pc_r[forced_rd_i];
  assign waw_o.victim_pc = wb_hit ? wb_i.pc : mem_i.pc;
  assign waw_o.in_wb = wb_hit;

endmodule

/* hdl/vcore_wb_top.sv */
`timescale 1ns/1ps

module vcore_wb_top #(
  parameter int resp_fifo_depth_p = 4
) (
  input  logic                    clk_i,
  input  logic                    reset_i,
  input  logic                    instr_v_i,
  input  vcore_pkg::instr_s       instr_i,
  input  logic                    remote_resp_v_i,
  input  vcore_pkg::remote_resp_s remote_resp_i,
  input  vcore_pkg::reg_addr_t    rf_raddr_i,
  output logic                    stall_o,
  output logic                    remote_req_v_o,
  output vcore_pkg::remote_req_s  remote_req_o,
  output vcore_pkg::data_t        rf_rdata_o,
  output logic                    waw_v_o,
  output vcore_pkg::waw_report_s  waw_o,
  output logic                    resp_overflow_o
);

  import vcore_pkg::*;

  stage_s mem_r;
  stage_s wb_r;
  logic head_v;
  remote_resp_s head;
  logic pop;
  logic stall;
  logic force_grant;
  rf_write_s rf_write;

  exe_pipe pipe (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .instr_v_i      (instr_v_i),
    .instr_i        (instr_i),
    .stall_i        (stall),
    .remote_req_v_o (remote_req_v_o),
    .remote_req_o   (remote_req_o),
    .mem_o          (mem_r),
    .wb_o           (wb_r)
  );

  remote_resp_fifo #(
    .resp_fifo_depth_p (resp_fifo_depth_p)
  ) resp_fifo (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .push_i      (remote_resp_v_i),
    .push_data_i (remote_resp_i),
    .pop_i       (pop),
    .head_v_o    (head_v),
    .head_o      (head),
    .overflow_o  (resp_overflow_o)
  );

  rf_write_arbiter arb (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .wb_i          (wb_r),
    .head_v_i      (head_v),
    .head_i        (head),
    .pop_o         (pop),
    .stall_o       (stall),
    .force_grant_o (force_grant),
    .rf_write_o    (rf_write)
  );

  regfile rf (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .write_i (rf_write),
    .raddr_i (rf_raddr_i),
    .rdata_o (rf_rdata_o)
  );

  waw_detector waw (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .remote_req_v_i (remote_req_v_o),
    .remote_req_i   (remote_req_o),
    .force_grant_i  (force_grant),
    .forced_rd_i    (head.rd),
    .mem_i          (mem_r),
    .wb_i           (wb_r),
    .waw_v_o        (waw_v_o),
    .waw_o          (waw_o)
  );

  assign stall_o = stall;

endmodule

/* sim/vcore_wb_tb.sv */
`timescale 1ns/1ps

module vcore_wb_tb;

  import vcore_pkg::*;

  parameter int resp_fifo_depth_p = 4;

  localparam int clk_period_lp = 20;
  localparam int reset_cycles_lp = 4;
  // cycle budget of each test, a little above what it needs
  localparam int local_cycles_lp = 16;
  localparam int remote_cycles_lp = 12;
  localparam int order_cycles_lp = 20;
  localparam int forced_cycles_lp = 4 * 14;
  localparam int overflow_cycles_lp = 3 * resp_fifo_depth_p + 16;
  localparam int margin_cycles_lp = 50;
  localparam int watchdog_ns_lp = clk_period_lp * (reset_cycles_lp + local_cycles_lp
    + remote_cycles_lp + order_cycles_lp + forced_cycles_lp + overflow_cycles_lp
    + margin_cycles_lp);

  logic         clk_i;
  logic         reset_i;
  logic         instr_v_i;
  instr_s       instr_i;
  logic         remote_resp_v_i;
  remote_resp_s remote_resp_i;
  reg_addr_t    rf_raddr_i;
  logic         stall_o;
  logic         remote_req_v_o;
  remote_req_s  remote_req_o;
  data_t        rf_rdata_o;
  logic         waw_v_o;
  waw_report_s  waw_o;
  logic         resp_overflow_o;

  // expected register file contents
  data_t ref_rf [reg_els_gp];
  int err_count;

  vcore_wb_top #(
    .resp_fifo_depth_p (resp_fifo_depth_p)
  ) DUT (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .instr_v_i       (instr_v_i),
    .instr_i         (instr_i),
    .remote_resp_v_i (remote_resp_v_i),
    .remote_resp_i   (remote_resp_i),
    .rf_raddr_i      (rf_raddr_i),
    .stall_o         (stall_o),
    .remote_req_v_o  (remote_req_v_o),
    .remote_req_o    (remote_req_o),
    .rf_rdata_o      (rf_rdata_o),
    .waw_v_o         (waw_v_o),
    .waw_o           (waw_o),
    .resp_overflow_o (resp_overflow_o)
  );

  always #(clk_period_lp / 2) clk_i = ~clk_i;

  task automatic check_data(input string name, input data_t got, input data_t exp);
    if (got !== exp) begin
      err_count++;
      $display("FAIL %s: got %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_pc(input string name, input pc_t got, input pc_t exp);
    if (got !== exp) begin
      err_count++;
      $display("FAIL %s: got %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_addr(input string name, input reg_addr_t got, input reg_addr_t exp);
    if (got !== exp) begin
      err_count++;
      $display("FAIL %s: got %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      err_count++;
      $display("FAIL %s: got %h, expected %h at %0t", name, got, exp, $time);
    end
  endtask

  // one step lands 2 ns after the next rising edge and ends all strobes
  task automatic tick();
    @(posedge clk_i);
    #2;
    instr_v_i = 1'b0;
    remote_resp_v_i = 1'b0;
  endtask

  task automatic ticks(input int n);
    repeat (n) begin
      tick();
    end
  endtask

  task automatic drive_instr(input pc_t pc, input reg_addr_t rd, input logic writes,
                             input logic remote, input data_t data);
    while (stall_o) begin
      tick();
    end
    instr_v_i = 1'b1;
    instr_i.pc = pc;
    instr_i.rd = rd;
    instr_i.writes_rf = writes;
    instr_i.remote_load = remote;
    instr_i.data = data;
  endtask

  task automatic drive_resp(input reg_addr_t rd, input data_t data, input logic force_wb);
    remote_resp_v_i = 1'b1;
    remote_resp_i.rd = rd;
    remote_resp_i.data = data;
    remote_resp_i.force_wb = force_wb;
  endtask

  // x0 stays zero whatever is written to it
  task automatic model_write(input reg_addr_t addr, input data_t data);
    if (addr != '0) begin
      ref_rf[addr] = data;
    end
  endtask

  task automatic check_reg(input reg_addr_t addr);
    rf_raddr_i = addr;
    #0.1;
    check_data($sformatf("rf_rdata_o[x%0d]", addr), rf_rdata_o, ref_rf[addr]);
  endtask

  task automatic check_all_regs();
    for (int i = 0; i < reg_els_gp; i++) begin
      check_reg(reg_addr_t'(i));
    end
  endtask

  task automatic reset_state_test();
    check_flag("stall_o", stall_o, 1'b0);
    check_flag("remote_req_v_o", remote_req_v_o, 1'b0);
    check_flag("waw_v_o", waw_v_o, 1'b0);
    check_flag("resp_overflow_o", resp_overflow_o, 1'b0);
    check_all_regs();
  endtask

  task automatic local_write_test();
    data_t d;
    reg_addr_t rd;
    data_t burst_d [3];
    reg_addr_t burst_rd [3];
    d = $urandom;
    drive_instr(32'h1000, 5'd5, 1'b1, 1'b0, d);
    ticks(3);
    // two edges in the pipe is not enough yet
    check_reg(5'd5);
    tick();
    model_write(5'd5, d);
    check_reg(5'd5);
    for (int i = 0; i < 3; i++) begin
      rd = (i == 0) ? reg_addr_t'(0) : reg_addr_t'(4 + 2 * i);
      burst_rd[i] = rd;
      burst_d[i] = $urandom;
      drive_instr(32'h1010 + 4 * i, rd, 1'b1, 1'b0, burst_d[i]);
      tick();
    end
    ticks(3);
    for (int i = 0; i < 3; i++) begin
      model_write(burst_rd[i], burst_d[i]);
    end
    check_all_regs();
  endtask

  task automatic remote_load_test();
    data_t resp_d;
    resp_d = $urandom;
    drive_instr(32'h2000, 5'd7, 1'b1, 1'b1, $urandom);
    check_flag("remote_req_v_o", remote_req_v_o, 1'b0);
    tick();
    check_flag("remote_req_v_o", remote_req_v_o, 1'b1);
    check_addr("remote_req_o.reg_id", remote_req_o.reg_id, 5'd7);
    check_pc("remote_req_o.pc", remote_req_o.pc, 32'h2000);
    tick();
    check_flag("remote_req_v_o", remote_req_v_o, 1'b0);
    ticks(2);
    // its own wb has passed without a write
    check_reg(5'd7);
    drive_resp(5'd7, resp_d, 1'b0);
    ticks(2);
    model_write(5'd7, resp_d);
    check_reg(5'd7);
  endtask

  task automatic response_order_test();
    data_t instr_d [6];
    reg_addr_t resp_rd [3];
    data_t resp_d [3];
    resp_rd[0] = 5'd20;
    resp_rd[1] = 5'd21;
    resp_rd[2] = 5'd20;
    for (int j = 0; j < 3; j++) begin
      resp_d[j] = $urandom;
    end
    for (int i = 0; i < 6; i++) begin
      instr_d[i] = $urandom;
      drive_instr(32'h3000 + 4 * i, reg_addr_t'(10 + i), 1'b1, 1'b0, instr_d[i]);
      if (i >= 2 && i <= 4) begin
        drive_resp(resp_rd[i - 2], resp_d[i - 2], 1'b0);
      end
      tick();
    end
    ticks(2);
    for (int i = 0; i < 5; i++) begin
      model_write(reg_addr_t'(10 + i), instr_d[i]);
    end
    check_all_regs();
    tick();
    model_write(5'd15, instr_d[5]);
    check_all_regs();
    // wb is idle from here, one response per edge
    for (int j = 0; j < 3; j++) begin
      tick();
      model_write(resp_rd[j], resp_d[j]);
      check_all_regs();
    end
  endtask

  task automatic forced_case(input int push_at, input reg_addr_t rd,
                             input reg_addr_t victim_rd, input pc_t base_pc);
    data_t v_d;
    data_t w_d;
    data_t r_d;
    reg_addr_t w_rd;
    logic hit;
    v_d = $urandom;
    w_d = $urandom;
    r_d = $urandom;
    w_rd = 5'd25;
    hit = (victim_rd == rd) && (rd != '0);
    drive_instr(base_pc, rd, 1'b1, 1'b1, $urandom);
    tick();
    check_flag("remote_req_v_o", remote_req_v_o, 1'b1);
    check_pc("remote_req_o.pc", remote_req_o.pc, base_pc);
    drive_instr(base_pc + 4, victim_rd, 1'b1, 1'b0, v_d);
    tick();
    drive_instr(base_pc + 8, w_rd, 1'b1, 1'b0, w_d);
    if (push_at == 2) begin
      drive_resp(rd, r_d, 1'b1);
    end
    tick();
    if (push_at == 3) begin
      drive_resp(rd, r_d, 1'b1);
      tick();
    end
    // the forced head owns the port in this cycle
    check_flag("stall_o", stall_o, 1'b1);
    check_flag("waw_v_o", waw_v_o, hit);
    if (hit) begin
      check_addr("waw_o.rd", waw_o.rd, rd);
      check_pc("waw_o.aggressor_pc", waw_o.aggressor_pc, base_pc);
      check_pc("waw_o.victim_pc", waw_o.victim_pc, base_pc + 4);
      check_flag("waw_o.in_wb", waw_o.in_wb, push_at == 3);
    end
    tick();
    model_write(rd, r_d);
    check_flag("stall_o", stall_o, 1'b0);
    check_flag("waw_v_o", waw_v_o, 1'b0);
    check_reg(rd);
    ticks((push_at == 2) ? 3 : 2);
    model_write(victim_rd, v_d);
    model_write(w_rd, w_d);
    check_all_regs();
    tick();
  endtask

  task automatic forced_write_test();
    forced_case(2, 5'd9, 5'd9, 32'h4000);
    forced_case(3, 5'd9, 5'd9, 32'h4100);
    forced_case(2, 5'd15, 5'd16, 32'h4200);
    forced_case(3, 5'd17, 5'd18, 32'h4300);
  endtask

  task automatic overflow_test();
    int n_instr;
    int n_resp;
    data_t d;
    data_t instr_d [$];
    data_t resp_d [$];
    n_instr = resp_fifo_depth_p + 4;
    n_resp = resp_fifo_depth_p + 2;
    check_flag("resp_overflow_o", resp_overflow_o, 1'b0);
    for (int k = 0; k < n_instr; k++) begin
      d = $urandom;
      instr_d.push_back(d);
      drive_instr(32'h5000 + 4 * k, reg_addr_t'(1 + (k % 8)), 1'b1, 1'b0, d);
      if (k >= 2 && k < 2 + n_resp) begin
        d = $urandom;
        resp_d.push_back(d);
        drive_resp(reg_addr_t'(20 + k - 2), d, 1'b0);
      end
      tick();
    end
    check_flag("resp_overflow_o", resp_overflow_o, 1'b1);
    ticks(resp_fifo_depth_p + 3);
    for (int k = 0; k < n_instr; k++) begin
      model_write(reg_addr_t'(1 + (k % 8)), instr_d[k]);
    end
    // the last two responses were dropped
    for (int j = 0; j < resp_fifo_depth_p; j++) begin
      model_write(reg_addr_t'(20 + j), resp_d[j]);
    end
    check_all_regs();
    check_flag("resp_overflow_o", resp_overflow_o, 1'b1);
  endtask

  initial begin
    #(watchdog_ns_lp);
    $display("timeout: the tests did not finish within %0d ns", watchdog_ns_lp);
    $display("TESTS FAILED");
    $finish;
  end

  initial begin
    void'($urandom(9));
    err_count = 0;
    clk_i = 1'b0;
    reset_i = 1'b1;
    instr_v_i = 1'b0;
    instr_i = '0;
    remote_resp_v_i = 1'b0;
    remote_resp_i = '0;
    rf_raddr_i = '0;
    for (int i = 0; i < reg_els_gp; i++) begin
      ref_rf[i] = '0;
    end
    repeat (reset_cycles_lp) @(posedge clk_i);
    #2;
    reset_i = 1'b0;
    reset_state_test();
    local_write_test();
    remote_load_test();
    response_order_test();
    forced_write_test();
    overflow_test();
    $display("checks done with %0d errors", err_count);
    if (err_count == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* vlog.f */
hdl/vcore_pkg.sv
hdl/exe_pipe.sv
hdl/remote_resp_fifo.sv
hdl/rf_write_arbiter.sv
hdl/regfile.sv
hdl/waw_detector.sv
hdl/vcore_wb_top.sv
sim/vcore_wb_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= vcore_wb_tb
FILELIST ?= vlog.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
DEPTH ?= 4
VFLAGS ?= --binary --timing

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG DEPTH VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Gresp_fifo_depth_p=$(DEPTH) --Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@grep -q "^TESTS PASSED$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
